/* tb.f */
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_branch.sv
verilog/ex_lsu.sv
verilog/ex_divider.sv
verilog/ex_commit.sv
verilog/ex_top.sv
verification/ex_asserts.sv
verification/ex_tb.sv

/* verification/ex_asserts.sv */
// concurrent checks on the divider start, busy and ready strobes, bound into ex_divider
`timescale 1ns/1ps
`default_nettype none

module ex_asserts (
    input logic clk_i,
    input logic rst_i,
    input logic start_i,
    input logic busy_i,
    input logic ready_i
);

    int fail_count = 0;

    a_ready_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        ready_i |=> !ready_i)
        else begin
            fail_count++;
            $error("divider ready was high for more than one cycle");
        end

    a_ready_not_busy: assert property (@(posedge clk_i) disable iff (rst_i)
        ready_i |-> !busy_i)
        else begin
            fail_count++;
            $error("divider ready and busy were high together");
        end

    // commit holds start back while a divide runs
    a_no_start_busy: assert property (@(posedge clk_i) disable iff (rst_i)
        busy_i |-> !start_i)
        else begin
            fail_count++;
            $error("a divide start reached the divider while it was busy");
        end

    a_start_busy: assert property (@(posedge clk_i) disable iff (rst_i)
        (start_i && !busy_i) |=> busy_i)
        else begin
            fail_count++;
            $error("divider did not go busy after a start");
        end

endmodule

bind ex_divider ex_asserts u_asserts (
    .clk_i    (clk),
    .rst_i    (rst_i),
    .start_i  (div_req_i.start),
    .busy_i   (div_rsp_o.busy),
    .ready_i  (div_rsp_o.ready)
);

`default_nettype wire

/* verification/ex_tb.sv */
// directed testbench for the execute stage, drives ex_top and checks it against a reference model
`timescale 1ns/1ps
`default_nettype none

module ex_tb;

    localparam int HALF_PERIOD = 50;
    localparam int SETTLE      = 10;  // sample point after the falling edge
    localparam int RST_CYCLES  = 4;
    localparam int N_ALU       = 200;
    localparam int N_BR        = 8;   // random pairs per branch condition
    localparam int N_DIV       = 4;   // random operand sets per divide op
    localparam int DIV_WAIT    = ex_pkg::DIV_STEPS + 2;  // falling edges from issue to write-back
    // one cycle per check, divides take a full wait each
    localparam int TEST_CYCLES = RST_CYCLES + N_ALU + 6 * 2 * N_BR + 4 + 20 + 12
                                 + (4 * N_DIV + 4) * (DIV_WAIT + 2);
    localparam int TIMEOUT_CYCLES = 3 * TEST_CYCLES;

    logic                    clk;
    logic                    rst_i;
    ex_pkg::ex_req_t         req;
    ex_pkg::ex_req_t         nop;
    logic [ex_pkg::XLEN-1:0] mem_rdata;
    ex_pkg::wb_t             wb;
    ex_pkg::mem_req_t        mem;
    ex_pkg::jump_t           jump;
    logic                    hold;
    logic [31:0]             lcg_state;
    int                      cycle_count = 0;
    int                      check_count = 0;
    int                      error_count = 0;

    ex_top u_dut (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_i       (req),
        .mem_rdata_i (mem_rdata),
        .wb_o        (wb),
        .mem_o       (mem),
        .jump_o      (jump),
        .hold_o      (hold)
    );

    initial clk = 1'b0;
    always #HALF_PERIOD clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    function logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task expect_eq(input string test, input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("MISMATCH %s expected %h actual %h", test, exp, act);
        end
    endtask

    task drive(input ex_pkg::ex_req_t r, input logic [31:0] rdata);
        @(negedge clk);
        req       = r;
        mem_rdata = rdata;
        #SETTLE;
    endtask

    function logic [31:0] alu_ref(input logic is_reg, input logic [2:0] f3, input logic b30,
                                  input logic [31:0] a, input logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] fill;
        sh   = b[4:0];
        fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;  // sign bits shifted in
        case (f3)
            3'd0:    alu_ref = (is_reg && b30) ? a - b : a + b;
            3'd1:    alu_ref = a << sh;
            3'd2:    alu_ref = ((a[31] != b[31]) ? a[31] : (a < b)) ? 32'd1 : 32'd0;
            3'd3:    alu_ref = (a < b) ? 32'd1 : 32'd0;
            3'd4:    alu_ref = a ^ b;
            3'd5:    alu_ref = b30 ? ((a >> sh) | fill) : (a >> sh);
            3'd6:    alu_ref = a | b;
            default: alu_ref = a & b;
        endcase
    endfunction

    function logic [31:0] div_ref(input logic [1:0] op, input logic [31:0] a,
                                  input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic               overflow;
        sa       = a;
        sb       = b;
        overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        if (b == 32'h0) begin
            div_ref = op[1] ? a : 32'hffff_ffff;
        end else if (overflow && !op[0]) begin
            div_ref = op[1] ? 32'h0 : a;
        end else begin
            case (op)
                2'd0:    div_ref = sa / sb;
                2'd1:    div_ref = a / b;
                2'd2:    div_ref = sa % sb;
                default: div_ref = a % b;
            endcase
        end
    endfunction

    task test_alu();
        ex_pkg::ex_req_t r;
        logic [31:0]     rnd;
        logic [2:0]      f3;
        logic [6:0]      f7;
        logic            is_reg;
        logic [31:0]     imm;
        for (int i = 0; i < N_ALU; i++) begin
            rnd    = next_rand();
            imm    = next_rand();
            f3     = rnd[14:12];
            is_reg = rnd[31];  // high bit, the low LCG bits repeat quickly
            f7     = ((f3 == 3'd0 || f3 == 3'd5) && rnd[30]) ? 7'h20 : 7'h00;
            r        = '0;
            r.inst   = {f7, rnd[24:15], f3, rnd[11:7], is_reg ? ex_pkg::OP : ex_pkg::OP_IMM};
            r.op1    = next_rand();
            r.op2    = is_reg ? next_rand() : {{20{imm[11]}}, imm[11:0]};
            r.rd_we  = 1'b1;
            r.rd_addr = rnd[11:7];
            drive(r, next_rand());
            expect_eq("alu we", 1, wb.we);
            expect_eq("alu rd", r.rd_addr, wb.addr);
            expect_eq("alu data", alu_ref(is_reg, f3, f7[5], r.op1, r.op2), wb.data);
            expect_eq("alu jump", 0, jump.flag);
            expect_eq("alu mem req", 0, mem.req);
        end
    endtask

    task test_branch();
        ex_pkg::ex_req_t r;
        logic [31:0]     rnd;
        logic [2:0]      f3;
        logic            taken;
        for (int c = 0; c < 6; c++) begin
            f3 = (c < 2) ? 3'(c) : 3'(c + 2);  // 0,1,4,5,6,7
            for (int i = 0; i < 2 * N_BR; i++) begin
                rnd        = next_rand();
                r          = '0;
                r.inst     = {rnd[31:15], f3, rnd[11:7], ex_pkg::BRANCH};
                r.op1      = next_rand();
                r.op2      = i[0] ? r.op1 : next_rand();  // odd rounds compare equal
                r.op1_jump = next_rand();
                r.op2_jump = next_rand();
                r.rd_we    = 1'b1;
                r.rd_addr  = rnd[11:7];
                case (f3)
                    3'd0:    taken = (r.op1 == r.op2);
                    3'd1:    taken = (r.op1 != r.op2);
                    3'd4:    taken = ($signed(r.op1) < $signed(r.op2));
                    3'd5:    taken = ($signed(r.op1) >= $signed(r.op2));
                    3'd6:    taken = (r.op1 < r.op2);
                    default: taken = (r.op1 >= r.op2);
                endcase
                drive(r, next_rand());
                expect_eq("branch taken", taken, jump.flag);
                if (taken) begin
                    expect_eq("branch target", r.op1_jump + r.op2_jump, jump.addr);
                end
                expect_eq("branch we", 0, wb.we);
            end
        end
    endtask

    task test_jump();
        ex_pkg::ex_req_t r;
        logic [31:0]     rnd;
        ex_pkg::opcode_e opc;
        for (int k = 0; k < 4; k++) begin
            case (k)
                0:       opc = ex_pkg::JAL;
                1:       opc = ex_pkg::JALR;
                2:       opc = ex_pkg::LUI;
                default: opc = ex_pkg::AUIPC;
            endcase
            rnd        = next_rand();
            r          = '0;
            r.inst     = {rnd[31:12], rnd[11:7], opc};
            r.op1      = next_rand();
            r.op2      = next_rand();
            r.op1_jump = next_rand();
            r.op2_jump = next_rand();
            r.rd_we    = 1'b1;
            r.rd_addr  = rnd[11:7];
            drive(r, next_rand());
            expect_eq("link we", 1, wb.we);
            expect_eq("link rd", r.rd_addr, wb.addr);
            expect_eq("link data", r.op1 + r.op2, wb.data);
            expect_eq("link jump", (k < 2), jump.flag);
            if (k < 2) begin
                expect_eq("link target", r.op1_jump + r.op2_jump, jump.addr);
            end
        end
    endtask

    task test_load();
        ex_pkg::ex_req_t r;
        logic [31:0]     rnd;
        logic [31:0]     rdata;
        logic [7:0]      bt;
        logic [15:0]     hf;
        logic [31:0]     exp;
        for (int s = 0; s < 6; s++) begin
            for (int off = 0; off < 4; off++) begin
                if (s != 3) begin
                    rnd       = next_rand();
                    rdata     = next_rand();
                    r         = '0;
                    r.inst    = {rnd[31:15], 3'(s), rnd[11:7], ex_pkg::LOAD};
                    r.op1     = next_rand();
                    r.op2     = next_rand();
                    r.op2[1:0] = 2'(off) - r.op1[1:0];
                    r.rd_we   = 1'b1;
                    r.rd_addr = rnd[11:7];
                    bt = 8'(rdata >> (8 * off));
                    hf = (off >= 2) ? rdata[31:16] : rdata[15:0];
                    case (s)
                        0:       exp = {{24{bt[7]}}, bt};
                        1:       exp = {{16{hf[15]}}, hf};
                        2:       exp = rdata;
                        4:       exp = {24'h0, bt};
                        default: exp = {16'h0, hf};
                    endcase
                    drive(r, rdata);
                    expect_eq("load req", 1, mem.req);
                    expect_eq("load mem we", 0, mem.we);
                    expect_eq("load raddr", r.op1 + r.op2, mem.raddr);
                    expect_eq("load we", 1, wb.we);
                    expect_eq("load rd", r.rd_addr, wb.addr);
                    expect_eq("load data", exp, wb.data);
                end
            end
        end
    endtask

    task test_store();
        ex_pkg::ex_req_t r;
        logic [31:0]     rnd;
        logic [31:0]     rdata;
        logic [31:0]     mask;
        int              sh;
        for (int s = 0; s < 3; s++) begin
            for (int off = 0; off < 4; off++) begin
                rnd        = next_rand();
                rdata      = next_rand();
                r          = '0;
                r.inst     = {rnd[31:15], 3'(s), rnd[11:7], ex_pkg::STORE};
                r.op1      = next_rand();
                r.op2      = next_rand();
                r.op2[1:0] = 2'(off) - r.op1[1:0];
                r.rs2_data = next_rand();
                r.rd_we    = 1'b1;
                r.rd_addr  = rnd[11:7];
                // lane of the access inside the word
                sh   = (s == 0) ? 8 * off : (s == 1) ? 16 * (off / 2) : 0;
                mask = (s == 0) ? 32'h0000_00ff : (s == 1) ? 32'h0000_ffff : 32'hffff_ffff;
                mask = mask << sh;
                drive(r, rdata);
                expect_eq("store req", 1, mem.req);
                expect_eq("store mem we", 1, mem.we);
                expect_eq("store waddr", r.op1 + r.op2, mem.waddr);
                expect_eq("store wdata", (rdata & ~mask) | ((r.rs2_data << sh) & mask),
                          mem.wdata);
                expect_eq("store no write-back", 0, wb.we);
            end
        end
    endtask

    task run_div(input logic [1:0] op, input logic [31:0] a, input logic [31:0] b);
        ex_pkg::ex_req_t r;
        logic [31:0]     rnd;
        int              waits;
        rnd        = next_rand();
        r          = '0;
        r.inst     = {7'b0000001, rnd[24:15], 1'b1, op, rnd[11:7], ex_pkg::OP};
        r.op1      = next_rand();
        r.op2      = next_rand();
        r.op1_jump = next_rand();
        r.op2_jump = next_rand();
        r.rs1_data = a;
        r.rs2_data = b;
        r.rd_we    = 1'b1;
        r.rd_addr  = rnd[11:7];
        drive(r, next_rand());
        expect_eq("div issue hold", 1, hold);
        expect_eq("div issue jump", 1, jump.flag);
        expect_eq("div issue target", r.op1_jump + r.op2_jump, jump.addr);
        expect_eq("div issue we", 0, wb.we);
        waits = 0;
        do begin
            drive(nop, next_rand());
            waits++;
            if (!wb.we) begin
                expect_eq("div busy hold", 1, hold);
            end
        end while (!wb.we);
        expect_eq("div latency", DIV_WAIT, waits);
        expect_eq("div rd", r.rd_addr, wb.addr);
        expect_eq("div result", div_ref(op, a, b), wb.data);
        expect_eq("div hold released", 0, hold);
        drive(nop, next_rand());
        expect_eq("div idle hold", 0, hold);
        expect_eq("div single write", 0, wb.we);
    endtask

    task test_div();
        logic [31:0] rnd;
        for (int op = 0; op < 4; op++) begin
            for (int i = 0; i < N_DIV; i++) begin
                rnd = next_rand();
                run_div(2'(op), next_rand(), next_rand() >> rnd[4:0]);  // spread of divisor sizes
            end
        end
        run_div(2'd0, next_rand(), 32'h0);
        run_div(2'd3, next_rand(), 32'h0);
        run_div(2'd0, 32'h8000_0000, 32'hffff_ffff);
        run_div(2'd2, 32'h8000_0000, 32'hffff_ffff);
    endtask

    initial begin
        lcg_state = 32'he06d_8ab4;
        rst_i     = 1'b1;
        req       = '0;
        nop       = '0;
        mem_rdata = '0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        #SETTLE;
        expect_eq("reset hold", 0, hold);
        test_alu();
        test_branch();
        test_jump();
        test_load();
        test_store();
        test_div();
        $display("checks %0d, errors %0d, assertion failures %0d", check_count, error_count,
                 u_dut.u_divider.u_asserts.fail_count);
        if (error_count == 0 && u_dut.u_divider.u_asserts.fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/ex_alu.sv */
// integer ALU of the execute stage for register and immediate forms, also exports op1/op2 compares
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
    input  ex_pkg::ex_req_t req_i,
    output ex_pkg::wb_t     alu_wb_o,
    output ex_pkg::cmp_t    cmp_o
);

    ex_pkg::opcode_e             opcode;
    logic [ex_pkg::XLEN-1:0]     op1;
    logic [ex_pkg::XLEN-1:0]     op2;
    logic [4:0]                  shamt;
    logic [6:0]                  funct7;
    logic                        alt;      // inst bit 30
    logic                        is_op;
    logic                        is_imm;
    logic                        wr_en;
    logic [ex_pkg::XLEN-1:0]     sra_res;
    logic [ex_pkg::XLEN-1:0]     result;

    assign opcode = ex_pkg::opcode_e'(req_i.inst[6:0]);
    assign op1    = req_i.op1;
    assign op2    = req_i.op2;
    assign shamt  = op2[4:0];
    assign funct7 = req_i.inst[31:25];
    assign alt    = req_i.inst[30];

    assign is_op  = (opcode == ex_pkg::OP);
    assign is_imm = (opcode == ex_pkg::OP_IMM);

    // funct7 of 1 is a divide, owned by the commit logic
    assign wr_en = req_i.rd_we &
                   (is_imm | (is_op & ((funct7 == 7'h00) | (funct7 == 7'h20))));

    assign cmp_o.eq  = (op1 == op2);
    assign cmp_o.lt  = ($signed(op1) < $signed(op2));
    assign cmp_o.ltu = (op1 < op2);

    assign sra_res = $signed(op1) >>> shamt;

    always_comb begin
        case (ex_pkg::alu_f3_e'(req_i.inst[14:12]))
            ex_pkg::F3_ADD: begin
                if (is_op && alt) begin
                    result = op1 - op2;
                end else begin
                    result = op1 + op2;  // addi ignores bit 30
                end
            end
            ex_pkg::F3_SLL:  result = op1 << shamt;
            ex_pkg::F3_SLT:  result = {{(ex_pkg::XLEN-1){1'b0}}, cmp_o.lt};
            ex_pkg::F3_SLTU: result = {{(ex_pkg::XLEN-1){1'b0}}, cmp_o.ltu};
            ex_pkg::F3_XOR:  result = op1 ^ op2;
            ex_pkg::F3_SR: begin
                if (alt) begin
                    result = sra_res;
                end else begin
                    result = op1 >> shamt;
                end
            end
            ex_pkg::F3_OR:   result = op1 | op2;
            ex_pkg::F3_AND:  result = op1 & op2;
            default:         result = '0;
        endcase
    end

    always_comb begin
        alu_wb_o = '0;
        if (wr_en) begin
            alu_wb_o.we   = 1'b1;
            alu_wb_o.addr = req_i.rd_addr;
            alu_wb_o.data = result;
        end
    end

endmodule

`default_nettype wire

/* verilog/ex_branch.sv */
// branch, jal/jalr and lui/auipc handling of the execute stage, gives jump target and link write
`timescale 1ns/1ps
`default_nettype none

module ex_branch (
    input  ex_pkg::ex_req_t req_i,
    input  ex_pkg::cmp_t    cmp_i,
    output ex_pkg::jump_t   br_jump_o,
    output ex_pkg::wb_t     link_wb_o
);

    ex_pkg::opcode_e         opcode;
    logic [ex_pkg::XLEN-1:0] target;
    logic [ex_pkg::XLEN-1:0] link;
    logic                    taken;
    logic                    do_link;

    assign opcode = ex_pkg::opcode_e'(req_i.inst[6:0]);
    assign target = req_i.op1_jump + req_i.op2_jump;
    assign link   = req_i.op1 + req_i.op2;  // pc+4, imm or pc+imm

    always_comb begin
        taken   = 1'b0;
        do_link = 1'b0;
        case (opcode)
            ex_pkg::BRANCH: begin
                case (ex_pkg::branch_f3_e'(req_i.inst[14:12]))
                    ex_pkg::F3_BEQ:  taken = cmp_i.eq;
                    ex_pkg::F3_BNE:  taken = ~cmp_i.eq;
                    ex_pkg::F3_BLT:  taken = cmp_i.lt;
                    ex_pkg::F3_BGE:  taken = ~cmp_i.lt;
                    ex_pkg::F3_BLTU: taken = cmp_i.ltu;
                    ex_pkg::F3_BGEU: taken = ~cmp_i.ltu;
                    default:         taken = 1'b0;
                endcase
            end
            ex_pkg::JAL, ex_pkg::JALR: begin
                taken   = 1'b1;
                do_link = 1'b1;
            end
            ex_pkg::LUI, ex_pkg::AUIPC: do_link = 1'b1;
            default: ;
        endcase
    end

    assign br_jump_o.flag = taken;
    assign br_jump_o.addr = taken ? target : '0;

    assign link_wb_o.we   = do_link & req_i.rd_we;
    assign link_wb_o.addr = link_wb_o.we ? req_i.rd_addr : '0;
    assign link_wb_o.data = link_wb_o.we ? link : '0;

endmodule

`default_nettype wire

/* verilog/ex_commit.sv */
// divide issue, hold and re-fetch jump, plus OR merge of all write-back and jump sources
`timescale 1ns/1ps
`default_nettype none

module ex_commit (
    input  ex_pkg::ex_req_t  req_i,
    input  ex_pkg::wb_t      alu_wb_i,
    input  ex_pkg::wb_t      link_wb_i,
    input  ex_pkg::wb_t      ld_wb_i,
    input  ex_pkg::jump_t    br_jump_i,
    input  ex_pkg::div_rsp_t div_rsp_i,
    output ex_pkg::div_req_t div_req_o,
    output ex_pkg::wb_t      wb_o,
    output ex_pkg::jump_t    jump_o,
    output logic             hold_o
);

    ex_pkg::opcode_e         opcode;
    logic                    is_div;
    logic                    issue;
    logic [ex_pkg::XLEN-1:0] refetch;
    ex_pkg::wb_t             div_wb;

    assign opcode  = ex_pkg::opcode_e'(req_i.inst[6:0]);
    // funct7 1 with funct3[2] set selects div/divu/rem/remu
    assign is_div  = (opcode == ex_pkg::OP) & (req_i.inst[31:25] == 7'b0000001) &
                     req_i.inst[14];
    assign issue   = is_div & ~div_rsp_i.busy;
    assign refetch = req_i.op1_jump + req_i.op2_jump;  // next instruction

    assign div_req_o.start    = issue;
    assign div_req_o.op       = ex_pkg::div_op_e'(req_i.inst[13:12]);
    assign div_req_o.dividend = req_i.rs1_data;
    assign div_req_o.divisor  = req_i.rs2_data;
    assign div_req_o.rd       = req_i.rd_addr;

    assign div_wb.we   = div_rsp_i.ready;
    assign div_wb.addr = div_rsp_i.ready ? div_rsp_i.rd : '0;
    assign div_wb.data = div_rsp_i.ready ? div_rsp_i.result : '0;

    // idle sources are all zero
    assign wb_o = alu_wb_i | link_wb_i | ld_wb_i | div_wb;

    assign jump_o.flag = br_jump_i.flag | issue;
    assign jump_o.addr = br_jump_i.addr | (issue ? refetch : '0);

    assign hold_o = issue | div_rsp_i.busy;

endmodule

`default_nettype wire

/* verilog/ex_divider.sv */
// iterative restoring divider for div/divu/rem/remu, started by a strobe and answering with ready
`timescale 1ns/1ps
`default_nettype none

module ex_divider (
    input  logic             clk,
    input  logic             rst_i,
    input  ex_pkg::div_req_t div_req_i,
    output ex_pkg::div_rsp_t div_rsp_o
);

    typedef enum logic [1:0] {
        IDLE,
        CALC,
        DONE
    } state_e;

    state_e                        state_q;
    logic [ex_pkg::DIV_CNT_W-1:0]  step_q;
    logic                          ready_q;
    ex_pkg::div_op_e               op_q;
    logic [ex_pkg::REG_ADDR_W-1:0] rd_q;
    logic                          quo_neg_q;
    logic                          rem_neg_q;
    logic                          div_zero_q;
    logic [ex_pkg::XLEN-1:0]       divisor_q;
    logic [ex_pkg::XLEN-1:0]       quo_q;
    logic [ex_pkg::XLEN-1:0]       rem_q;
    logic [ex_pkg::XLEN-1:0]       result_q;

    logic                          accept;
    logic                          signed_op;
    logic                          dvd_neg;
    logic                          dvs_neg;
    logic [ex_pkg::XLEN-1:0]       dvd_mag;
    logic [ex_pkg::XLEN-1:0]       dvs_mag;
    logic [ex_pkg::XLEN:0]         trial;
    logic [ex_pkg::XLEN:0]         diff;
    logic                          sub_ok;
    logic [ex_pkg::XLEN-1:0]       quo_fix;
    logic [ex_pkg::XLEN-1:0]       rem_fix;

    assign accept    = (state_q == IDLE) & div_req_i.start;  // no restart while busy
    assign signed_op = (div_req_i.op == ex_pkg::DIV) | (div_req_i.op == ex_pkg::REM);
    assign dvd_neg   = signed_op & div_req_i.dividend[ex_pkg::XLEN-1];
    assign dvs_neg   = signed_op & div_req_i.divisor[ex_pkg::XLEN-1];
    assign dvd_mag   = dvd_neg ? -div_req_i.dividend : div_req_i.dividend;
    assign dvs_mag   = dvs_neg ? -div_req_i.divisor : div_req_i.divisor;

    // one restoring step per clock
    assign trial  = {rem_q, quo_q[ex_pkg::XLEN-1]};
    assign diff   = trial - {1'b0, divisor_q};
    assign sub_ok = ~diff[ex_pkg::XLEN];

    // most-negative / -1 falls out of the magnitudes as the dividend itself
    assign quo_fix = div_zero_q ? '1 : (quo_neg_q ? -quo_q : quo_q);
    assign rem_fix = rem_neg_q ? -rem_q : rem_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= IDLE;
            step_q  <= '0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    step_q <= '0;
                    if (accept) begin
                        state_q <= CALC;
                    end
                end
                CALC: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == (ex_pkg::DIV_STEPS - 1)) begin
                        state_q <= DONE;
                    end
                end
                DONE: begin
                    state_q <= IDLE;
                    ready_q <= 1'b1;  // result_q valid in this same cycle
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q       <= div_req_i.op;
            rd_q       <= div_req_i.rd;
            quo_neg_q  <= dvd_neg ^ dvs_neg;
            rem_neg_q  <= dvd_neg;
            div_zero_q <= (div_req_i.divisor == '0);
            divisor_q  <= dvs_mag;
            quo_q      <= dvd_mag;  // dividend shifts out as quotient shifts in
            rem_q      <= '0;
        end else if (state_q == CALC) begin
            quo_q <= {quo_q[ex_pkg::XLEN-2:0], sub_ok};
            rem_q <= sub_ok ? diff[ex_pkg::XLEN-1:0] : trial[ex_pkg::XLEN-1:0];
        end else if (state_q == DONE) begin
            if ((op_q == ex_pkg::REM) || (op_q == ex_pkg::REMU)) begin
                result_q <= rem_fix;
            end else begin
                result_q <= quo_fix;
            end
        end
    end

    assign div_rsp_o.busy   = (state_q != IDLE);
    assign div_rsp_o.ready  = ready_q;
    assign div_rsp_o.result = result_q;
    assign div_rsp_o.rd     = rd_q;

endmodule

`default_nettype wire

/* verilog/ex_lsu.sv */
// load extraction and store byte merge of the execute stage, drives the data memory request
`timescale 1ns/1ps
`default_nettype none

module ex_lsu (
    input  ex_pkg::ex_req_t        req_i,
    input  logic [ex_pkg::XLEN-1:0] mem_rdata_i,
    output ex_pkg::mem_req_t       mem_o,
    output ex_pkg::wb_t            ld_wb_o
);

    ex_pkg::opcode_e         opcode;
    ex_pkg::mem_f3_e         size;
    logic [ex_pkg::XLEN-1:0] addr;
    logic [1:0]              off;
    logic [4:0]              byte_sh;
    logic [4:0]              half_sh;
    logic [7:0]              ld_byte;
    logic [15:0]             ld_half;
    logic [ex_pkg::XLEN-1:0] ld_data;
    logic [ex_pkg::XLEN-1:0] st_data;
    logic                    ld_ok;
    logic                    st_ok;

    assign opcode  = ex_pkg::opcode_e'(req_i.inst[6:0]);
    assign size    = ex_pkg::mem_f3_e'(req_i.inst[14:12]);
    assign addr    = req_i.op1 + req_i.op2;
    assign off     = addr[1:0];
    assign byte_sh = {off, 3'b000};
    assign half_sh = {off[1], 4'b0000};  // halves sit on bit 0 or 16

    assign ld_byte = mem_rdata_i[byte_sh +: 8];
    assign ld_half = mem_rdata_i[half_sh +: 16];

    always_comb begin
        ld_ok   = 1'b0;
        st_ok   = 1'b0;
        ld_data = '0;
        st_data = '0;
        if (opcode == ex_pkg::LOAD) begin
            ld_ok = 1'b1;
            case (size)
                ex_pkg::F3_B:  ld_data = {{(ex_pkg::XLEN-8){ld_byte[7]}}, ld_byte};
                ex_pkg::F3_H:  ld_data = {{(ex_pkg::XLEN-16){ld_half[15]}}, ld_half};
                ex_pkg::F3_W:  ld_data = mem_rdata_i;
                ex_pkg::F3_BU: ld_data = {{(ex_pkg::XLEN-8){1'b0}}, ld_byte};
                ex_pkg::F3_HU: ld_data = {{(ex_pkg::XLEN-16){1'b0}}, ld_half};
                default:       ld_ok   = 1'b0;
            endcase
        end
        if (opcode == ex_pkg::STORE) begin
            st_ok   = 1'b1;
            st_data = mem_rdata_i;  // word read back, lane patched below
            case (size)
                ex_pkg::F3_B: st_data[byte_sh +: 8]  = req_i.rs2_data[7:0];
                ex_pkg::F3_H: st_data[half_sh +: 16] = req_i.rs2_data[15:0];
                ex_pkg::F3_W: st_data = req_i.rs2_data;
                default: begin
                    st_ok   = 1'b0;
                    st_data = '0;
                end
            endcase
        end
    end

    assign mem_o.req   = ld_ok | st_ok;
    assign mem_o.we    = st_ok;
    assign mem_o.raddr = mem_o.req ? addr : '0;  // stores read the same word
    assign mem_o.waddr = st_ok ? addr : '0;
    assign mem_o.wdata = st_data;

    assign ld_wb_o.we   = ld_ok & req_i.rd_we;
    assign ld_wb_o.addr = ld_wb_o.we ? req_i.rd_addr : '0;
    assign ld_wb_o.data = ld_wb_o.we ? ld_data : '0;

endmodule

`default_nettype wire

/* verilog/ex_pkg.sv */
// shared widths, instruction encodings and bundle types of the execute stage, referenced as ex_pkg::name
`default_nettype none

package ex_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int DIV_STEPS  = 32;
    localparam int DIV_CNT_W  = $clog2(DIV_STEPS);

    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,  // add / sub
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,  // srl / sra
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } alu_f3_e;

    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } branch_f3_e;

    typedef enum logic [2:0] {
        F3_B  = 3'b000,
        F3_H  = 3'b001,
        F3_W  = 3'b010,
        F3_BU = 3'b100,
        F3_HU = 3'b101
    } mem_f3_e;

    // low funct3 bits of the M-extension divides
    typedef enum logic [1:0] {
        DIV  = 2'b00,
        DIVU = 2'b01,
        REM  = 2'b10,
        REMU = 2'b11
    } div_op_e;

    typedef struct packed {
        logic [31:0]           inst;
        logic [XLEN-1:0]       op1;
        logic [XLEN-1:0]       op2;
        logic [XLEN-1:0]       op1_jump;
        logic [XLEN-1:0]       op2_jump;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic                  rd_we;
        logic [REG_ADDR_W-1:0] rd_addr;
    } ex_req_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } wb_t;

    typedef struct packed {
        logic            req;
        logic            we;
        logic [XLEN-1:0] raddr;
        logic [XLEN-1:0] waddr;
        logic [XLEN-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic            flag;
        logic [XLEN-1:0] addr;
    } jump_t;

    // op1 against op2
    typedef struct packed {
        logic eq;
        logic lt;
        logic ltu;
    } cmp_t;

    typedef struct packed {
        logic                  start;
        div_op_e               op;
        logic [XLEN-1:0]       dividend;
        logic [XLEN-1:0]       divisor;
        logic [REG_ADDR_W-1:0] rd;
    } div_req_t;

    typedef struct packed {
        logic                  busy;
        logic                  ready;
        logic [XLEN-1:0]       result;
        logic [REG_ADDR_W-1:0] rd;
    } div_rsp_t;

endpackage

`default_nettype wire

/* verilog/ex_top.sv */
// execute stage top level, connects ALU, branch, load/store, commit and divider units
`timescale 1ns/1ps
`default_nettype none

module ex_top (
    input  logic                    clk,
    input  logic                    rst_i,
    input  ex_pkg::ex_req_t         req_i,
    input  logic [ex_pkg::XLEN-1:0] mem_rdata_i,
    output ex_pkg::wb_t             wb_o,
    output ex_pkg::mem_req_t        mem_o,
    output ex_pkg::jump_t           jump_o,
    output logic                    hold_o
);

    ex_pkg::wb_t      alu_wb;
    ex_pkg::wb_t      link_wb;
    ex_pkg::wb_t      ld_wb;
    ex_pkg::cmp_t     cmp;
    ex_pkg::jump_t    br_jump;
    ex_pkg::div_req_t div_req;
    ex_pkg::div_rsp_t div_rsp;

    ex_alu u_alu (
        .req_i    (req_i),
        .alu_wb_o (alu_wb),
        .cmp_o    (cmp)
    );

    ex_branch u_branch (
        .req_i     (req_i),
        .cmp_i     (cmp),
        .br_jump_o (br_jump),
        .link_wb_o (link_wb)
    );

    ex_lsu u_lsu (
        .req_i       (req_i),
        .mem_rdata_i (mem_rdata_i),
        .mem_o       (mem_o),
        .ld_wb_o     (ld_wb)
    );

    ex_commit u_commit (
        .req_i     (req_i),
        .alu_wb_i  (alu_wb),
        .link_wb_i (link_wb),
        .ld_wb_i   (ld_wb),
        .br_jump_i (br_jump),
        .div_rsp_i (div_rsp),
        .div_req_o (div_req),
        .wb_o      (wb_o),
        .jump_o    (jump_o),
        .hold_o    (hold_o)
    );

    ex_divider u_divider (
        .clk       (clk),
        .rst_i     (rst_i),
        .div_req_i (div_req),
        .div_rsp_o (div_rsp)
    );

endmodule

`default_nettype wire
